//--- design/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// datapath widths
`define WORD_W 32
`define REG_ADDR_W 5

// first fetch address after reset
`define PC_RESET_ADDR 32'h0000_0000

// r0 always reads as zero
`define REG_ZERO 5'd0

`define ZERO_WORD 32'h0000_0000

// the all-zero word decodes as a no-op
`define NOP_INST 32'h0000_0000

`endif

//--- design/cpu_pkg.sv
package cpu_pkg;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_ADDIU,
        OP_ORI,
        OP_LUI,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_J
    } oper_e;

    // primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OPC_SPECIAL = 6'b000000,
        OPC_J       = 6'b000010,
        OPC_BEQ     = 6'b000100,
        OPC_BNE     = 6'b000101,
        OPC_ADDIU   = 6'b001001,
        OPC_ORI     = 6'b001101,
        OPC_LUI     = 6'b001111,
        OPC_LW      = 6'b100011,
        OPC_SW      = 6'b101011
    } opcode_e;

    // function field of SPECIAL instructions, bits 5:0
    typedef enum logic [5:0] {
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101
    } funct_e;

endpackage

//--- design/inst_decoder.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module inst_decoder (
    input  logic [`WORD_W-1:0]     inst_i,
    output cpu_pkg::oper_e         oper_o,
    output logic                   reg1_read_o,
    output logic                   reg2_read_o,
    output logic                   wreg_write_o,
    output logic [`REG_ADDR_W-1:0] reg1_addr_o,
    output logic [`REG_ADDR_W-1:0] reg2_addr_o,
    output logic [`REG_ADDR_W-1:0] wreg_addr_o,
    output logic [`WORD_W-1:0]     imm_o
);
    import cpu_pkg::*;

    opcode_e                opcode;
    funct_e                 funct;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`WORD_W-1:0]     imm_sext;

    assign opcode   = opcode_e'(inst_i[31:26]);
    assign funct    = funct_e'(inst_i[5:0]);
    assign rt       = inst_i[20:16];
    assign rd       = inst_i[15:11];
    assign imm_sext = {{(`WORD_W-16){inst_i[15]}}, inst_i[15:0]};

    // source fields are passed through, the enables decide whether they count
    assign reg1_addr_o = inst_i[25:21];
    assign reg2_addr_o = rt;

    always_comb begin
        oper_o       = OP_NOP;
        reg1_read_o  = 1'b0;
        reg2_read_o  = 1'b0;
        wreg_write_o = 1'b0;
        wreg_addr_o  = `REG_ZERO;
        imm_o        = `ZERO_WORD;
        case (opcode)
            OPC_SPECIAL: begin
                reg1_read_o  = 1'b1;
                reg2_read_o  = 1'b1;
                wreg_write_o = 1'b1;
                wreg_addr_o  = rd;
                case (funct)
                    FN_ADDU: oper_o = OP_ADDU;
                    FN_SUBU: oper_o = OP_SUBU;
                    FN_AND:  oper_o = OP_AND;
                    FN_OR:   oper_o = OP_OR;
                    default: begin
                        // unknown function codes fall back to a no-op
                        reg1_read_o  = 1'b0;
                        reg2_read_o  = 1'b0;
                        wreg_write_o = 1'b0;
                        wreg_addr_o  = `REG_ZERO;
                    end
                endcase
            end
            OPC_ADDIU, OPC_ORI, OPC_LW: begin
                reg1_read_o  = 1'b1;
                wreg_write_o = 1'b1;
                wreg_addr_o  = rt;
                imm_o        = imm_sext;
                if (opcode == OPC_ORI) begin
                    oper_o = OP_ORI;
                    imm_o  = {{(`WORD_W-16){1'b0}}, inst_i[15:0]};
                end else if (opcode == OPC_LW) begin
                    oper_o = OP_LW;
                end else begin
                    oper_o = OP_ADDIU;
                end
            end
            OPC_LUI: begin
                oper_o       = OP_LUI;
                wreg_write_o = 1'b1;
                wreg_addr_o  = rt;
                imm_o        = {inst_i[15:0], {(`WORD_W-16){1'b0}}};
            end
            OPC_SW, OPC_BEQ, OPC_BNE: begin
                reg1_read_o = 1'b1;
                reg2_read_o = 1'b1;
                imm_o       = imm_sext;
                if (opcode == OPC_SW) begin
                    oper_o = OP_SW;
                end else if (opcode == OPC_BEQ) begin
                    oper_o = OP_BEQ;
                end else begin
                    oper_o = OP_BNE;
                end
            end
            OPC_J: begin
                oper_o = OP_J;
                imm_o  = {{(`WORD_W-26){1'b0}}, inst_i[25:0]};
            end
            default: ;
        endcase
    end

endmodule

//--- design/branch_unit.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module branch_unit (
    input  cpu_pkg::oper_e     oper_i,
    input  logic [`WORD_W-1:0] pc_i,
    input  logic [`WORD_W-1:0] reg1_i,
    input  logic [`WORD_W-1:0] reg2_i,
    input  logic [`WORD_W-1:0] imm_i,
    output logic               branch_flag_o,
    output logic [`WORD_W-1:0] branch_target_o
);
    import cpu_pkg::*;

    logic [`WORD_W-1:0] pc_plus4;

    // targets are relative to the delay slot address
    assign pc_plus4 = pc_i + `WORD_W'(4);

    always_comb begin
        branch_flag_o   = 1'b0;
        branch_target_o = pc_plus4 + {imm_i[`WORD_W-3:0], 2'b00};
        case (oper_i)
            OP_BEQ: branch_flag_o = (reg1_i == reg2_i);
            OP_BNE: branch_flag_o = (reg1_i != reg2_i);
            OP_J: begin
                branch_flag_o   = 1'b1;
                branch_target_o = {pc_plus4[`WORD_W-1:28], imm_i[25:0], 2'b00};
            end
            default: ;
        endcase
    end

endmodule

//--- design/id_stage.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module id_stage (
    input  logic [`WORD_W-1:0]     pc_i,
    input  logic [`WORD_W-1:0]     inst_i,
    input  logic [`WORD_W-1:0]     reg1_data_i,
    input  logic [`WORD_W-1:0]     reg2_data_i,
    input  cpu_pkg::oper_e         ex_oper_i,
    input  logic                   ex_wreg_write_i,
    input  logic [`REG_ADDR_W-1:0] ex_wreg_addr_i,
    input  logic [`WORD_W-1:0]     ex_wreg_data_i,
    input  logic                   mem_wreg_write_i,
    input  logic [`REG_ADDR_W-1:0] mem_wreg_addr_i,
    input  logic [`WORD_W-1:0]     mem_wreg_data_i,
    output logic [`REG_ADDR_W-1:0] reg1_addr_o,
    output logic [`REG_ADDR_W-1:0] reg2_addr_o,
    output cpu_pkg::oper_e         oper_o,
    output logic [`WORD_W-1:0]     reg1_o,
    output logic [`WORD_W-1:0]     reg2_o,
    output logic                   wreg_write_o,
    output logic [`REG_ADDR_W-1:0] wreg_addr_o,
    output logic                   next_in_delayslot_o,
    output logic                   branch_flag_o,
    output logic [`WORD_W-1:0]     branch_target_o,
    output logic                   stallreq_o
);
    import cpu_pkg::*;

    logic               reg1_read;
    logic               reg2_read;
    logic [`WORD_W-1:0] imm;
    logic [`WORD_W-1:0] reg1_fwd;
    logic [`WORD_W-1:0] reg2_fwd;

    inst_decoder u_decoder (
        .inst_i       (inst_i),
        .oper_o       (oper_o),
        .reg1_read_o  (reg1_read),
        .reg2_read_o  (reg2_read),
        .wreg_write_o (wreg_write_o),
        .reg1_addr_o  (reg1_addr_o),
        .reg2_addr_o  (reg2_addr_o),
        .wreg_addr_o  (wreg_addr_o),
        .imm_o        (imm)
    );

    // ======================================================================
    // operand forwarding
    // ======================================================================

    // EX wins over MEM, MEM wins over the register file
    function automatic logic [`WORD_W-1:0] pick_operand(
        input logic                   rd_en,
        input logic [`REG_ADDR_W-1:0] addr,
        input logic [`WORD_W-1:0]     rf_data
    );
        logic [`WORD_W-1:0] val;
        if (!rd_en) begin
            val = imm;
        end else if (ex_wreg_write_i && ex_wreg_addr_i == addr) begin
            val = (addr == `REG_ZERO) ? `ZERO_WORD : ex_wreg_data_i;
        end else if (mem_wreg_write_i && mem_wreg_addr_i == addr) begin
            val = (addr == `REG_ZERO) ? `ZERO_WORD : mem_wreg_data_i;
        end else begin
            val = rf_data;
        end
        return val;
    endfunction

    always_comb begin
        reg1_fwd = pick_operand(reg1_read, reg1_addr_o, reg1_data_i);
        reg2_fwd = pick_operand(reg2_read, reg2_addr_o, reg2_data_i);
    end

    // a store hands the finished address to execute
    assign reg1_o = (oper_o == OP_SW) ? reg1_fwd + imm : reg1_fwd;
    assign reg2_o = reg2_fwd;

    branch_unit u_branch (
        .oper_i          (oper_o),
        .pc_i            (pc_i),
        .reg1_i          (reg1_fwd),
        .reg2_i          (reg2_fwd),
        .imm_i           (imm),
        .branch_flag_o   (branch_flag_o),
        .branch_target_o (branch_target_o)
    );

    assign next_in_delayslot_o = (oper_o == OP_BEQ) || (oper_o == OP_BNE) || (oper_o == OP_J);

    // load data is not ready until MEM, so a dependent instruction waits a cycle
    assign stallreq_o = (ex_oper_i == OP_LW) &&
                        ((reg1_read && ex_wreg_addr_i == reg1_addr_o) ||
                         (reg2_read && ex_wreg_addr_i == reg2_addr_o));

endmodule

//--- design/regfile.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module regfile (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`REG_ADDR_W-1:0] raddr1_i,
    input  logic [`REG_ADDR_W-1:0] raddr2_i,
    input  logic                   we_i,
    input  logic [`REG_ADDR_W-1:0] waddr_i,
    input  logic [`WORD_W-1:0]     wdata_i,
    output logic [`WORD_W-1:0]     rdata1_o,
    output logic [`WORD_W-1:0]     rdata2_o
);

    logic [`WORD_W-1:0] regs [2**`REG_ADDR_W];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                regs[i] <= `ZERO_WORD;
            end
        end else if (we_i && waddr_i != `REG_ZERO) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through so decode sees a value written back in the same cycle
    assign rdata1_o = (raddr1_i == `REG_ZERO) ? `ZERO_WORD :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == `REG_ZERO) ? `ZERO_WORD :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

//--- design/pipeline_ctrl.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module pipeline_ctrl (
    input  logic clk_i,
    input  logic rst_n_i,
    input  logic stallreq_i,
    input  logic next_in_delayslot_i,
    output logic hold_o,
    output logic bubble_o,
    output logic in_delayslot_o
);

    // a load-use stall freezes fetch and decode and sends a NOP to execute
    assign hold_o   = stallreq_i;
    assign bubble_o = stallreq_i;

    // the instruction decoded after a branch is its delay slot
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_delayslot_o <= 1'b0;
        end else if (!hold_o) begin
            in_delayslot_o <= next_in_delayslot_i;
        end
    end

endmodule

//--- design/fetch_stage.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module fetch_stage (
    input  logic               clk_i,
    input  logic               rst_n_i,
    input  logic               hold_i,
    input  logic               branch_flag_i,
    input  logic [`WORD_W-1:0] branch_target_i,
    input  logic [`WORD_W-1:0] inst_i,
    output logic [`WORD_W-1:0] pc_o,
    output logic [`WORD_W-1:0] id_pc_o,
    output logic [`WORD_W-1:0] id_inst_o
);

    logic [`WORD_W-1:0] next_pc;

    // hold wins, since a stalled branch may still see stale operands
    always_comb begin
        if (hold_i) begin
            next_pc = pc_o;
        end else if (branch_flag_i) begin
            next_pc = branch_target_i;
        end else begin
            next_pc = pc_o + `WORD_W'(4);
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pc_o <= `PC_RESET_ADDR;
        end else begin
            pc_o <= next_pc;
        end
    end

    // ======================================================================
    // IF/ID register
    // ======================================================================

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            id_pc_o   <= `PC_RESET_ADDR;
            id_inst_o <= `NOP_INST;
        end else if (!hold_i) begin
            id_pc_o   <= pc_o;
            id_inst_o <= inst_i;
        end
    end

endmodule

//--- design/id_ex_reg.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module id_ex_reg (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   bubble_i,
    input  cpu_pkg::oper_e         oper_i,
    input  logic [`WORD_W-1:0]     reg1_i,
    input  logic [`WORD_W-1:0]     reg2_i,
    input  logic                   wreg_write_i,
    input  logic [`REG_ADDR_W-1:0] wreg_addr_i,
    input  logic                   in_delayslot_i,
    output cpu_pkg::oper_e         ex_oper_o,
    output logic [`WORD_W-1:0]     ex_reg1_o,
    output logic [`WORD_W-1:0]     ex_reg2_o,
    output logic                   ex_wreg_write_o,
    output logic [`REG_ADDR_W-1:0] ex_wreg_addr_o,
    output logic                   ex_in_delayslot_o
);
    import cpu_pkg::*;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ex_oper_o         <= OP_NOP;
            ex_wreg_write_o   <= 1'b0;
            ex_wreg_addr_o    <= `REG_ZERO;
            ex_in_delayslot_o <= 1'b0;
        end else if (bubble_i) begin
            ex_oper_o         <= OP_NOP;
            ex_wreg_write_o   <= 1'b0;
            ex_wreg_addr_o    <= `REG_ZERO;
            ex_in_delayslot_o <= 1'b0;
        end else begin
            ex_oper_o         <= oper_i;
            ex_wreg_write_o   <= wreg_write_i;
            ex_wreg_addr_o    <= wreg_addr_i;
            ex_in_delayslot_o <= in_delayslot_i;
        end
    end

    // operands are payload and follow decode every cycle
    always_ff @(posedge clk_i) begin
        ex_reg1_o <= bubble_i ? `ZERO_WORD : reg1_i;
        ex_reg2_o <= bubble_i ? `ZERO_WORD : reg2_i;
    end

endmodule

//--- design/cpu_frontend.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpu_frontend (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic [`WORD_W-1:0]     inst_i,
    input  logic [`WORD_W-1:0]     ex_result_i,
    input  logic                   mem_wreg_write_i,
    input  logic [`REG_ADDR_W-1:0] mem_wreg_addr_i,
    input  logic [`WORD_W-1:0]     mem_wreg_data_i,
    input  logic                   wb_write_i,
    input  logic [`REG_ADDR_W-1:0] wb_addr_i,
    input  logic [`WORD_W-1:0]     wb_data_i,
    output logic [`WORD_W-1:0]     inst_addr_o,
    output cpu_pkg::oper_e         ex_oper_o,
    output logic [`WORD_W-1:0]     ex_reg1_o,
    output logic [`WORD_W-1:0]     ex_reg2_o,
    output logic                   ex_wreg_write_o,
    output logic [`REG_ADDR_W-1:0] ex_wreg_addr_o,
    output logic                   ex_in_delayslot_o,
    output logic                   stall_o
);
    import cpu_pkg::*;

    logic [`WORD_W-1:0]     if_pc;
    logic [`WORD_W-1:0]     if_inst;
    logic [`REG_ADDR_W-1:0] reg1_addr;
    logic [`REG_ADDR_W-1:0] reg2_addr;
    logic [`WORD_W-1:0]     reg1_data;
    logic [`WORD_W-1:0]     reg2_data;
    oper_e                  id_oper;
    logic [`WORD_W-1:0]     id_reg1;
    logic [`WORD_W-1:0]     id_reg2;
    logic                   id_wreg_write;
    logic [`REG_ADDR_W-1:0] id_wreg_addr;
    logic                   next_in_delayslot;
    logic                   in_delayslot;
    logic                   branch_flag;
    logic [`WORD_W-1:0]     branch_target;
    logic                   stallreq;
    logic                   hold;
    logic                   bubble;

    assign stall_o = hold;

    fetch_stage u_fetch (
        .clk_i           (clk_i),
        .rst_n_i         (rst_n_i),
        .hold_i          (hold),
        .branch_flag_i   (branch_flag),
        .branch_target_i (branch_target),
        .inst_i          (inst_i),
        .pc_o            (inst_addr_o),
        .id_pc_o         (if_pc),
        .id_inst_o       (if_inst)
    );

    regfile u_regfile (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .raddr1_i (reg1_addr),
        .raddr2_i (reg2_addr),
        .we_i     (wb_write_i),
        .waddr_i  (wb_addr_i),
        .wdata_i  (wb_data_i),
        .rdata1_o (reg1_data),
        .rdata2_o (reg2_data)
    );

    id_stage u_id (
        .pc_i                (if_pc),
        .inst_i              (if_inst),
        .reg1_data_i         (reg1_data),
        .reg2_data_i         (reg2_data),
        .ex_oper_i           (ex_oper_o),
        .ex_wreg_write_i     (ex_wreg_write_o),
        .ex_wreg_addr_i      (ex_wreg_addr_o),
        .ex_wreg_data_i      (ex_result_i),
        .mem_wreg_write_i    (mem_wreg_write_i),
        .mem_wreg_addr_i     (mem_wreg_addr_i),
        .mem_wreg_data_i     (mem_wreg_data_i),
        .reg1_addr_o         (reg1_addr),
        .reg2_addr_o         (reg2_addr),
        .oper_o              (id_oper),
        .reg1_o              (id_reg1),
        .reg2_o              (id_reg2),
        .wreg_write_o        (id_wreg_write),
        .wreg_addr_o         (id_wreg_addr),
        .next_in_delayslot_o (next_in_delayslot),
        .branch_flag_o       (branch_flag),
        .branch_target_o     (branch_target),
        .stallreq_o          (stallreq)
    );

    pipeline_ctrl u_ctrl (
        .clk_i               (clk_i),
        .rst_n_i             (rst_n_i),
        .stallreq_i          (stallreq),
        .next_in_delayslot_i (next_in_delayslot),
        .hold_o              (hold),
        .bubble_o            (bubble),
        .in_delayslot_o      (in_delayslot)
    );

    id_ex_reg u_id_ex (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .bubble_i          (bubble),
        .oper_i            (id_oper),
        .reg1_i            (id_reg1),
        .reg2_i            (id_reg2),
        .wreg_write_i      (id_wreg_write),
        .wreg_addr_i       (id_wreg_addr),
        .in_delayslot_i    (in_delayslot),
        .ex_oper_o         (ex_oper_o),
        .ex_reg1_o         (ex_reg1_o),
        .ex_reg2_o         (ex_reg2_o),
        .ex_wreg_write_o   (ex_wreg_write_o),
        .ex_wreg_addr_o    (ex_wreg_addr_o),
        .ex_in_delayslot_o (ex_in_delayslot_o)
    );

endmodule

//--- test/cpu_frontend_assertions.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module cpu_frontend_assertions (
    input logic                   clk_i,
    input logic                   rst_n_i,
    input logic [`WORD_W-1:0]     inst_addr_o,
    input cpu_pkg::oper_e         ex_oper_o,
    input logic                   ex_wreg_write_o,
    input logic                   ex_in_delayslot_o,
    input logic                   stall_o,
    input logic                   branch_flag,
    input logic [`WORD_W-1:0]     branch_target,
    input logic                   next_in_delayslot
);
    import cpu_pkg::*;

    int fail_cnt = 0;

    // ======================================================================
    // reset values
    // ======================================================================

    reset_state: assert property (@(posedge clk_i)
        !rst_n_i |-> inst_addr_o == `PC_RESET_ADDR && ex_oper_o == OP_NOP &&
                     !ex_wreg_write_o && !stall_o)
    else begin
        fail_cnt++;
        $error("front end left its reset state while reset was held");
    end

    // ======================================================================
    // load-use stall
    // ======================================================================

    stall_holds_pc: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        stall_o |=> inst_addr_o == $past(inst_addr_o) && ex_oper_o == OP_NOP &&
                    !ex_wreg_write_o && !stall_o)
    else begin
        fail_cnt++;
        $error("stall did not hold the PC for exactly one bubble");
    end

    // ======================================================================
    // branches and delay slot
    // ======================================================================

    branch_redirect: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        branch_flag && !stall_o |=> inst_addr_o == $past(branch_target))
    else begin
        fail_cnt++;
        $error("fetch did not go to the branch target");
    end

    delay_slot_flag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        next_in_delayslot && !stall_o |=> ##1 ex_in_delayslot_o)
    else begin
        fail_cnt++;
        $error("instruction after a branch was not marked as a delay slot");
    end

endmodule

bind cpu_frontend cpu_frontend_assertions u_assert (.*);

//--- test/tb_cpu_frontend.sv
`timescale 1ns/10ps
`include "cpu_settings.svh"

module tb_cpu_frontend;
    import cpu_pkg::*;

    localparam int CLK_PERIOD = 40;
    // program length, one load-use stall, reset and some margin
    localparam int RUN_CYCLES = 64 + 1 + 3 + 20;
    localparam logic [31:0] EX_VAL  = 32'hE0E0_0001;
    localparam logic [31:0] MEM_VAL = 32'h5A5A_0009;

    logic clk_i = 1'b0;
    logic rst_n_i;
    logic [31:0] ex_result_i;
    logic mem_wreg_write_i;
    logic [4:0] mem_wreg_addr_i;
    logic [31:0] mem_wreg_data_i;
    logic wb_write_i;
    logic [4:0] wb_addr_i;
    logic [31:0] wb_data_i;
    logic [31:0] inst_addr_o;
    oper_e ex_oper_o;
    logic [31:0] ex_reg1_o;
    logic [31:0] ex_reg2_o;
    logic ex_wreg_write_o;
    logic [4:0] ex_wreg_addr_o;
    logic ex_in_delayslot_o;
    logic stall_o;

    logic [31:0] rom [64];
    logic [31:0] reg_m [32];
    oper_e exp_oper [64];
    logic exp_wen [64];
    logic [4:0] exp_waddr [64];
    logic [31:0] exp_r1 [64];
    logic [31:0] exp_r2 [64];
    logic exp_ds [64];
    int exp_q [$];
    int errors = 0;
    int edges = 0;
    logic was_stall = 1'b0;

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // instruction memory answers in the same cycle
    wire [31:0] inst_w = rom[inst_addr_o[7:2]];

    cpu_frontend dut0 (
        .clk_i, .rst_n_i, .inst_i(inst_w), .ex_result_i,
        .mem_wreg_write_i, .mem_wreg_addr_i, .mem_wreg_data_i,
        .wb_write_i, .wb_addr_i, .wb_data_i, .inst_addr_o, .ex_oper_o,
        .ex_reg1_o, .ex_reg2_o, .ex_wreg_write_o, .ex_wreg_addr_o,
        .ex_in_delayslot_o, .stall_o
    );

    function automatic logic [31:0] r_inst(funct_e fn, logic [4:0] rd, logic [4:0] rs,
                                           logic [4:0] rt);
        return {OPC_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_inst(opcode_e opc, logic [4:0] rt, logic [4:0] rs,
                                           logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic [31:0] sext16(logic [15:0] x);
        return {{16{x[15]}}, x};
    endfunction

    task automatic place(int idx, logic [31:0] inst, oper_e op, logic wen, logic [4:0] wa,
                         logic [31:0] a, logic [31:0] b, logic ds);
        rom[idx]       = inst;
        exp_oper[idx]  = op;
        exp_wen[idx]   = wen;
        exp_waddr[idx] = wa;
        exp_r1[idx]    = a;
        exp_r2[idx]    = b;
        exp_ds[idx]    = ds;
    endtask

    task automatic build_program();
        for (int i = 0; i < 64; i++) begin
            place(i, 32'h0, OP_NOP, 1'b0, 5'd0, 32'h0, 32'h0, 1'b0);
        end
        place(8, r_inst(FN_ADDU, 7, 1, 2), OP_ADDU, 1, 7, reg_m[1], reg_m[2], 0);
        place(9, r_inst(FN_SUBU, 8, 3, 4), OP_SUBU, 1, 8, reg_m[3], reg_m[4], 0);
        place(10, r_inst(FN_AND, 10, 5, 6), OP_AND, 1, 10, reg_m[5], reg_m[6], 0);
        place(11, r_inst(FN_OR, 11, 0, 1), OP_OR, 1, 11, 32'h0, reg_m[1], 0);
        place(12, i_inst(OPC_ORI, 12, 2, 16'h8001), OP_ORI, 1, 12, reg_m[2], 32'h8001, 0);
        place(13, i_inst(OPC_LUI, 13, 0, 16'h1234), OP_LUI, 1, 13, 32'h12340000,
              32'h12340000, 0);
        place(14, i_inst(OPC_ADDIU, 14, 3, 16'hFFFC), OP_ADDIU, 1, 14, reg_m[3],
              sext16(16'hFFFC), 0);
        // store address is base plus the sign-extended offset
        place(15, i_inst(OPC_SW, 4, 5, 16'd8), OP_SW, 0, 0, reg_m[5] + sext16(16'd8),
              reg_m[4], 0);
        place(16, r_inst(FN_ADDU, 15, 9, 1), OP_ADDU, 1, 15, MEM_VAL, reg_m[1], 0);
        place(17, i_inst(OPC_ADDIU, 9, 2, 16'd1), OP_ADDIU, 1, 9, reg_m[2], 32'd1, 0);
        // r9 is both in EX and MEM here and EX has priority
        place(18, r_inst(FN_ADDU, 16, 9, 0), OP_ADDU, 1, 16, EX_VAL, 32'h0, 0);
        place(19, i_inst(OPC_ADDIU, 0, 1, 16'd5), OP_ADDIU, 1, 0, reg_m[1], 32'd5, 0);
        place(20, r_inst(FN_OR, 17, 0, 2), OP_OR, 1, 17, 32'h0, reg_m[2], 0);
        place(21, i_inst(OPC_LW, 18, 1, 16'd0), OP_LW, 1, 18, reg_m[1], 32'h0, 0);
        place(22, r_inst(FN_ADDU, 19, 18, 3), OP_ADDU, 1, 19, 32'h0, reg_m[3], 0);
        place(23, i_inst(OPC_BEQ, 1, 1, 16'd3), OP_BEQ, 0, 0, reg_m[1], reg_m[1], 0);
        place(24, i_inst(OPC_ORI, 20, 0, 16'h24), OP_ORI, 1, 20, 32'h0, 32'h24, 1);
        rom[25] = i_inst(OPC_LUI, 24, 0, 16'hDEAD);
        rom[26] = i_inst(OPC_LUI, 25, 0, 16'hDEAD);
        place(27, i_inst(OPC_BNE, 2, 1, 16'd2), OP_BNE, 0, 0, reg_m[1], reg_m[2], 0);
        place(28, i_inst(OPC_ORI, 21, 0, 16'h28), OP_ORI, 1, 21, 32'h0, 32'h28, 1);
        rom[29] = i_inst(OPC_LUI, 26, 0, 16'hDEAD);
        place(30, i_inst(OPC_BEQ, 2, 1, 16'd5), OP_BEQ, 0, 0, reg_m[1], reg_m[2], 0);
        place(31, i_inst(OPC_ADDIU, 22, 0, 16'd7), OP_ADDIU, 1, 22, 32'h0, 32'd7, 1);
        place(32, {OPC_J, 26'd40}, OP_J, 0, 0, 32'd40, 32'd40, 0);
        place(33, i_inst(OPC_ADDIU, 23, 0, 16'd8), OP_ADDIU, 1, 23, 32'h0, 32'd8, 1);
        for (int i = 34; i < 40; i++) begin
            rom[i] = i_inst(OPC_LUI, 27, 0, 16'hDEAD);
        end
        for (int i = 0; i <= 24; i++) begin
            exp_q.push_back(i);
        end
        exp_q.push_back(27);
        exp_q.push_back(28);
        for (int i = 30; i <= 33; i++) begin
            exp_q.push_back(i);
        end
        for (int i = 40; i <= 44; i++) begin
            exp_q.push_back(i);
        end
    endtask

    task automatic compare_ex();
        int idx;
        idx = exp_q.pop_front();
        assert (ex_oper_o == exp_oper[idx] && ex_wreg_write_o == exp_wen[idx] &&
                ex_wreg_addr_o == exp_waddr[idx] && ex_in_delayslot_o == exp_ds[idx])
        else begin
            errors++;
            $display("CHECK FAILED at %0t: word %0d control oper=%s wen=%b waddr=%0d ds=%b",
                     $time, idx, ex_oper_o.name(), ex_wreg_write_o, ex_wreg_addr_o,
                     ex_in_delayslot_o);
        end
        assert (ex_reg1_o == exp_r1[idx] && ex_reg2_o == exp_r2[idx])
        else begin
            errors++;
            $display("CHECK FAILED at %0t: word %0d operands %h %h, expected %h %h",
                     $time, idx, ex_reg1_o, ex_reg2_o, exp_r1[idx], exp_r2[idx]);
        end
    endtask

    always @(posedge clk_i) begin
        if (rst_n_i && edges < 3) begin
            edges <= edges + 1;
        end
    end

    // outputs are sampled mid-cycle and the cycle after a stall carries a bubble
    always @(negedge clk_i) begin
        if (edges >= 2 && exp_q.size() > 0 && !was_stall) begin
            compare_ex();
        end
        was_stall = stall_o;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("timeout: the program did not reach its last instruction");
        $display("CHECKS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(73916));
        rst_n_i = 1'b0;
        ex_result_i = EX_VAL;
        mem_wreg_write_i = 1'b1;
        mem_wreg_addr_i = 5'd9;
        mem_wreg_data_i = MEM_VAL;
        wb_write_i = 1'b0;
        wb_addr_i = 5'd0;
        wb_data_i = 32'h0;
        for (int i = 0; i < 32; i++) begin
            reg_m[i] = 32'h0;
        end
        for (int i = 1; i <= 6; i++) begin
            reg_m[i] = $urandom();
        end
        if (reg_m[2] == reg_m[1]) begin
            reg_m[2] = reg_m[1] + 32'd1;
        end
        build_program();
        repeat (3) @(posedge clk_i);
        #2 rst_n_i = 1'b1;
        // preload finishes long before the first real instruction is decoded
        for (int i = 1; i <= 6; i++) begin
            @(posedge clk_i);
            #2;
            wb_write_i = 1'b1;
            wb_addr_i = 5'(i);
            wb_data_i = reg_m[i];
        end
        @(posedge clk_i);
        #2 wb_write_i = 1'b0;
        wait (exp_q.size() == 0);
        @(negedge clk_i);
        $display("errors: %0d value checks, %0d assertions", errors,
                 dut0.u_assert.fail_cnt);
        if (errors == 0 && dut0.u_assert.fail_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- compile.f
+incdir+design
design/cpu_pkg.sv
design/inst_decoder.sv
design/branch_unit.sv
design/id_stage.sv
design/regfile.sv
design/pipeline_ctrl.sv
design/fetch_stage.sv
design/id_ex_reg.sv
design/cpu_frontend.sv
test/cpu_frontend_assertions.sv
test/tb_cpu_frontend.sv

//--- Makefile
TOP = tb_cpu_frontend

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -o V$(TOP)

run: compile
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
